//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = elinkTxTb
FILELIST  = compile.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "All tests passed!"

clean:
	rm -rf $(OBJDIR)

//--- compile.f
+incdir+tests
design/elinkPkg.sv
design/elinkEnc8b10b.sv
design/elinkLane.sv
design/elinkWbFeeder.sv
design/elinkStatus.sv
design/elinkTxTop.sv
tests/elinkClkGen.sv
tests/elinkTxTb.sv

//--- design/elinkEnc8b10b.sv
// 8b10b encoder for data and K28.y words with running disparity tracking
`timescale 1ns/1ns
module elinkEnc8b10b (
  input  logic               getDataTrig,
  input  logic               rstN,
  input  elinkPkg::laneWordT word,
  input  logic               advance,  // symbol taken by the lane
  output logic [9:0]         symbol    // bit 0 = a, sent first
);

  logic       rdPos;   // running disparity, 1 = positive
  logic       rd6Pos;  // disparity between 6b and 4b blocks
  logic [4:0] x;       // EDCBA
  logic [2:0] y;       // HGF
  logic [5:0] code6;   // tables hold abcdei with a in msb
  logic [3:0] code4;   // fghj with f in msb
  logic       flip6;
  logic       flip4;
  logic       useA7;
  logic [3:0] onesCnt;

  always_comb
  begin
    x = word.kFlag ? 5'd28 : word.data[4:0];  // K words always K28.y
    y = word.data[7:5];

    // 5b/6b codes for RD-
    case (x)
      5'd0:  code6 = 6'b100111;
      5'd1:  code6 = 6'b011101;
      5'd2:  code6 = 6'b101101;
      5'd3:  code6 = 6'b110001;
      5'd4:  code6 = 6'b110101;
      5'd5:  code6 = 6'b101001;
      5'd6:  code6 = 6'b011001;
      5'd7:  code6 = 6'b111000;  // balanced but still flips
      5'd8:  code6 = 6'b111001;
      5'd9:  code6 = 6'b100101;
      5'd10: code6 = 6'b010101;
      5'd11: code6 = 6'b110100;
      5'd12: code6 = 6'b001101;
      5'd13: code6 = 6'b101100;
      5'd14: code6 = 6'b011100;
      5'd15: code6 = 6'b010111;
      5'd16: code6 = 6'b011011;
      5'd17: code6 = 6'b100011;
      5'd18: code6 = 6'b010011;
      5'd19: code6 = 6'b110010;
      5'd20: code6 = 6'b001011;
      5'd21: code6 = 6'b101010;
      5'd22: code6 = 6'b011010;
      5'd23: code6 = 6'b111010;
      5'd24: code6 = 6'b110011;
      5'd25: code6 = 6'b100110;
      5'd26: code6 = 6'b010110;
      5'd27: code6 = 6'b110110;
      5'd28: code6 = 6'b001110;
      5'd29: code6 = 6'b101110;
      5'd30: code6 = 6'b011110;
      5'd31: code6 = 6'b101011;
    endcase
    if (word.kFlag)
      code6 = 6'b001111;  // K.28

    flip6 = rdPos && (($countones(code6) != 3) || (x == 5'd7));
    if (flip6)
      code6 = ~code6;
    rd6Pos = rdPos ^ ($countones(code6) != 3);  // unbalanced block toggles rd

    // alternate x.7 avoids a run of five equal bits
    useA7 = !word.kFlag && (y == 3'd7) &&
            ((!rd6Pos && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
             (rd6Pos && (x == 5'd11 || x == 5'd13 || x == 5'd14)));

    // 3b/4b codes for RD-
    case (y)
      3'd0: code4 = 4'b1011;
      3'd1: code4 = 4'b1001;
      3'd2: code4 = 4'b0101;
      3'd3: code4 = 4'b1100;
      3'd4: code4 = 4'b1101;
      3'd5: code4 = 4'b1010;
      3'd6: code4 = 4'b0110;
      3'd7: code4 = 4'b1110;  // P7
    endcase
    if (useA7)
      code4 = 4'b0111;
    if (word.kFlag)
    begin
      case (y)
        3'd0: code4 = 4'b1011;
        3'd1: code4 = 4'b0110;
        3'd2: code4 = 4'b1010;
        3'd3: code4 = 4'b1100;
        3'd4: code4 = 4'b1101;
        3'd5: code4 = 4'b0101;
        3'd6: code4 = 4'b1001;
        3'd7: code4 = 4'b0111;
      endcase
    end

    // K codes always flip on RD+
    flip4 = rd6Pos && (word.kFlag || ($countones(code4) != 2) || (y == 3'd3));
    if (flip4)
      code4 = ~code4;

    for (int b = 0; b < 6; b++)
      symbol[b] = code6[5 - b];  // a lands in bit 0
    for (int b = 0; b < 4; b++)
      symbol[6 + b] = code4[3 - b];
  end

  assign onesCnt = 4'($countones(symbol));

  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
      rdPos <= 1'b0;  // start at RD-
    else if (advance && onesCnt != 4'd5)
      rdPos <= onesCnt == 4'd6;
  end

  aOnesCount: assert property (@(posedge getDataTrig) disable iff (!rstN)
    advance |-> onesCnt inside {4'd4, 4'd5, 4'd6});
  // an unbalanced symbol must always pull rd back the other way
  aDispBalance: assert property (@(posedge getDataTrig) disable iff (!rstN)
    advance && onesCnt != 4'd5 |-> (onesCnt == 4'd6) != rdPos);

endmodule

//--- design/elinkLane.sv
// one e-link lane that picks a word or idle comma, encodes it and shifts out two bits a cycle
`timescale 1ns/1ns
module elinkLane (
  input  logic               getDataTrig,
  input  logic               rstN,
  input  elinkPkg::laneWordT laneWord,
  input  logic               laneValid,
  output logic               lanePop,
  output logic               dataSent,
  output logic [1:0]         eData
);

  logic [elinkPkg::PHASE_W-1:0] phase;    // 0 = symbol boundary
  logic                         loadNow;
  elinkPkg::symKindT            kind;
  elinkPkg::laneWordT           encWord;
  logic [9:0]                   symbol;
  logic [7:0]                   shReg;    // remaining four pairs

  assign loadNow = phase == '0;
  assign kind    = laneValid ? elinkPkg::symData : elinkPkg::symIdle;
  // empty queue at the boundary sends K28.5
  assign encWord = (kind == elinkPkg::symData) ? laneWord :
                   '{kFlag: 1'b1, data: elinkPkg::K28_5};
  assign lanePop  = loadNow && (kind == elinkPkg::symData);  // take head word
  assign dataSent = lanePop;  // status counts data symbols only

  elinkEnc8b10b u_elinkEnc8b10b (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .word        (encWord),
    .advance     (loadNow),   // every symbol moves rd, idles included
    .symbol      (symbol)
  );

  // symbol phase and output pair
  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
    begin
      phase <= '0;
      eData <= 2'b00;
    end
    else
    begin
      if (phase == elinkPkg::PHASE_W'(elinkPkg::SYM_CYCLES - 1))
        phase <= '0;
      else
        phase <= phase + 1'b1;

      if (loadNow)
        eData <= symbol[1:0];  // bit 0 carries the earlier bit
      else
        eData <= shReg[1:0];
    end
  end

  always_ff @(posedge getDataTrig)
  begin
    if (loadNow)
      shReg <= symbol[9:2];
    else
      shReg <= shReg >> 2;  // LSB first
  end

  // at most one pop per symbol slot
  aPopPhase: assert property (@(posedge getDataTrig) disable iff (!rstN)
    lanePop |=> (!lanePop) [* elinkPkg::SYM_CYCLES - 1]);

endmodule

//--- design/elinkPkg.sv
// elink transmitter shared constants, bus structs and enums
package elinkPkg;

  localparam int NUM_LANES   = 4;
  localparam int QUEUE_DEPTH = 4;  // words per lane queue
  localparam int SYM_CYCLES  = 5;  // one 10b symbol every 5 cycles
  localparam int CNT_W       = 16;
  localparam int LANE_W      = $clog2(NUM_LANES);
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
  localparam int PHASE_W     = $clog2(SYM_CYCLES);

  localparam logic [7:0] K28_5 = 8'hBC;  // idle comma

  // host word for one lane
  typedef struct packed {
    logic       kFlag;
    logic [7:0] data;
  } laneWordT;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [15:0] dat;
  } wbReqT;

  typedef struct packed {
    logic        ack;
    logic [15:0] dat;
  } wbRspT;

  typedef logic [$clog2(QUEUE_DEPTH + 1) - 1:0] levelT;  // 0 .. QUEUE_DEPTH

  typedef enum logic {wbIdle, wbAck} wbStateT;

  typedef enum logic {symData, symIdle} symKindT;

endpackage

//--- design/elinkStatus.sv
// per-lane data symbol counters and queue levels for wishbone register reads
`timescale 1ns/1ns
module elinkStatus (
  input  logic                                       getDataTrig,
  input  logic                                       rstN,
  input  logic            [elinkPkg::NUM_LANES-1:0]  dataSent,
  input  elinkPkg::levelT [elinkPkg::NUM_LANES-1:0]  queueLevel,
  input  logic            [2:0]                      statAdr,
  output logic            [15:0]                     statData
);

  logic [elinkPkg::CNT_W-1:0]  symCnt [elinkPkg::NUM_LANES];
  logic [elinkPkg::LANE_W-1:0] sel;  // lane picked by the low address bits
  logic                        levelSel;

  assign sel      = statAdr[elinkPkg::LANE_W-1:0];
  assign levelSel = statAdr[2];  // adr 4..7 read levels

  for (genvar i = 0; i < elinkPkg::NUM_LANES; i++)
  begin : gCnt
    always_ff @(posedge getDataTrig or negedge rstN)
    begin
      if (!rstN)
        symCnt[i] <= '0;
      else if (dataSent[i])
        symCnt[i] <= symCnt[i] + 1'b1;  // wraps at 2**CNT_W
    end
  end

  // read mux
  always_comb
  begin
    if (levelSel)
      statData = 16'(queueLevel[sel]);  // zero extended
    else
      statData = 16'(symCnt[sel]);
  end

endmodule

//--- design/elinkTxTop.sv
// four-lane e-link transmitter top joining wishbone feeder, lanes and status block
`timescale 1ns/1ns
module elinkTxTop (
  input  logic                                   getDataTrig,
  input  logic                                   rstN,
  input  elinkPkg::wbReqT                        wbReq,
  output elinkPkg::wbRspT                        wbRsp,
  output logic [elinkPkg::NUM_LANES-1:0][1:0]    eData
);

  elinkPkg::laneWordT [elinkPkg::NUM_LANES-1:0] laneWord;
  logic               [elinkPkg::NUM_LANES-1:0] laneValid;
  logic               [elinkPkg::NUM_LANES-1:0] lanePop;
  logic               [elinkPkg::NUM_LANES-1:0] dataSent;
  elinkPkg::levelT    [elinkPkg::NUM_LANES-1:0] queueLevel;
  logic               [2:0]                     statAdr;
  logic               [15:0]                    statData;

  // host side and lane queues
  elinkWbFeeder u_elinkWbFeeder (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .wbReq       (wbReq),
    .wbRsp       (wbRsp),
    .laneWord    (laneWord),
    .laneValid   (laneValid),
    .lanePop     (lanePop),
    .queueLevel  (queueLevel),
    .statAdr     (statAdr),
    .statData    (statData)
  );

  for (genvar i = 0; i < elinkPkg::NUM_LANES; i++)
  begin : gLane
    elinkLane u_elinkLane (
      .getDataTrig (getDataTrig),
      .rstN        (rstN),
      .laneWord    (laneWord[i]),
      .laneValid   (laneValid[i]),
      .lanePop     (lanePop[i]),
      .dataSent    (dataSent[i]),
      .eData       (eData[i])    // lanes run in lockstep
    );
  end

  // counters and level readback
  elinkStatus u_elinkStatus (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .dataSent    (dataSent),
    .queueLevel  (queueLevel),
    .statAdr     (statAdr),
    .statData    (statData)
  );

endmodule

//--- design/elinkWbFeeder.sv
// wishbone classic slave feeding the per-lane word queues and muxing register reads
`timescale 1ns/1ns
module elinkWbFeeder (
  input  logic                                                getDataTrig,
  input  logic                                                rstN,
  input  elinkPkg::wbReqT                                     wbReq,
  output elinkPkg::wbRspT                                     wbRsp,
  output elinkPkg::laneWordT [elinkPkg::NUM_LANES-1:0]        laneWord,
  output logic               [elinkPkg::NUM_LANES-1:0]        laneValid,
  input  logic               [elinkPkg::NUM_LANES-1:0]        lanePop,
  output elinkPkg::levelT    [elinkPkg::NUM_LANES-1:0]        queueLevel,
  output logic               [2:0]                            statAdr,
  input  logic               [15:0]                           statData
);

  elinkPkg::wbStateT                   state;
  logic [elinkPkg::NUM_LANES-1:0]      full;
  logic [elinkPkg::NUM_LANES-1:0]      push;
  logic [elinkPkg::LANE_W-1:0]         lane;
  logic                                req;
  logic                                laneAdr;  // adr 0..3
  logic                                accept;   // access completes this edge
  logic [15:0]                         rdData;

  assign req     = wbReq.cyc && wbReq.stb;
  assign laneAdr = wbReq.adr[3:2] == 2'b00;
  assign lane    = wbReq.adr[elinkPkg::LANE_W-1:0];
  assign statAdr = wbReq.adr[2:0];  // status decodes count vs level
  // a write to a full queue waits here
  assign accept  = (state == elinkPkg::wbIdle) && req &&
                   !(wbReq.we && laneAdr && full[lane]);
  assign rdData  = (!wbReq.we && !wbReq.adr[3]) ? statData : '0;  // adr 8+ reads 0

  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= elinkPkg::wbIdle;
      wbRsp <= '0;
    end
    else
    begin
      case (state)
        elinkPkg::wbIdle:
        begin
          if (accept)
          begin
            state     <= elinkPkg::wbAck;
            wbRsp.ack <= 1'b1;
            wbRsp.dat <= rdData;  // read data rides with ack
          end
        end
        elinkPkg::wbAck:
        begin
          state     <= elinkPkg::wbIdle;  // single cycle ack
          wbRsp.ack <= 1'b0;
        end
      endcase
    end
  end

  for (genvar i = 0; i < elinkPkg::NUM_LANES; i++)
  begin : gQueue
    elinkPkg::laneWordT          mem [elinkPkg::QUEUE_DEPTH];
    logic [elinkPkg::QPTR_W-1:0] wrPtr;
    logic [elinkPkg::QPTR_W-1:0] rdPtr;
    elinkPkg::levelT             level;

    assign push[i] = accept && wbReq.we && laneAdr && (lane == elinkPkg::LANE_W'(i));

    always_ff @(posedge getDataTrig or negedge rstN)
    begin
      if (!rstN)
      begin
        wrPtr <= '0;
        rdPtr <= '0;
        level <= '0;
      end
      else
      begin
        if (push[i])
          wrPtr <= wrPtr + 1'b1;  // depth is a power of two so pointers wrap
        if (lanePop[i])
          rdPtr <= rdPtr + 1'b1;
        level <= level + elinkPkg::levelT'(push[i]) - elinkPkg::levelT'(lanePop[i]);
      end
    end

    always_ff @(posedge getDataTrig)
    begin
      if (push[i])
        mem[wrPtr] <= wbReq.dat[8:0];  // low 9 bits = {kFlag, data}
    end

    assign laneWord[i]   = mem[rdPtr];  // head word
    assign laneValid[i]  = level != '0;
    assign full[i]       = level == elinkPkg::QUEUE_DEPTH;
    assign queueLevel[i] = level;

    // queue never holds more than its depth
    aLevelBound: assert property (@(posedge getDataTrig) disable iff (!rstN)
      level <= elinkPkg::QUEUE_DEPTH);
    aPopNotEmpty: assert property (@(posedge getDataTrig) disable iff (!rstN)
      lanePop[i] |-> laneValid[i]);
  end

  // ack never outlives the master's request
  aAckInCycle: assert property (@(posedge getDataTrig) disable iff (!rstN)
    wbRsp.ack |-> wbReq.cyc && wbReq.stb);

endmodule

//--- tests/elinkClkGen.sv
// testbench clock source with a 40 ns period and reset held low for two cycles
`timescale 1ns/1ns
module elinkClkGen (
  output logic getDataTrig,
  output logic rstN
);

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 2;
  localparam int RELEASE_DLY  = 2;  // release just after the edge

  initial
  begin
    getDataTrig = 1'b0;
    forever #HALF_PERIOD getDataTrig = ~getDataTrig;
  end

  initial
  begin
    rstN = 1'b0;
    repeat (RESET_CYCLES) @(posedge getDataTrig);
    #RELEASE_DLY rstN = 1'b1;
  end

endmodule

//--- tests/elinkTxChecks.svh
// reference 8b10b model, compare tasks and wishbone bus tasks for the e-link testbench
`ifndef ELINK_TX_CHECKS_SVH
`define ELINK_TX_CHECKS_SVH

  // encode one word from a running disparity, a in bit 0
  function automatic logic [9:0] encode(input elinkPkg::laneWordT w, input logic rdIn,
                                        output logic rdOut);
    logic [0:31][5:0] d6;  // abcdei, RD- column
    logic [0:7][3:0]  d4;  // fghj, RD- column
    logic [0:7][3:0]  k4;
    logic [4:0]       x;
    logic [2:0]       y;
    logic [5:0]       c6;
    logic [3:0]       c4;
    logic             rdMid;
    logic             alt;
    logic [9:0]       sym;
    d6 = {6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
          6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
          6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
          6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011};
    d4 = {4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110};
    k4 = {4'b1011, 4'b0110, 4'b1010, 4'b1100, 4'b1101, 4'b0101, 4'b1001, 4'b0111};
    x = w.kFlag ? 5'd28 : w.data[4:0];  // any K word is K28.y
    y = w.data[7:5];
    c6 = w.kFlag ? 6'b001111 : d6[x];
    if (rdIn && ($countones(c6) != 3 || c6 == 6'b111000))
      c6 = ~c6;  // D.7 is neutral but still has two forms
    rdMid = ($countones(c6) == 3) ? rdIn : ($countones(c6) > 3);
    alt = !w.kFlag && y == 3'd7 &&
          (rdMid ? (x == 5'd11 || x == 5'd13 || x == 5'd14) :
                   (x == 5'd17 || x == 5'd18 || x == 5'd20));
    c4 = w.kFlag ? k4[y] : (alt ? 4'b0111 : d4[y]);
    if (rdMid && (w.kFlag || $countones(c4) != 2 || c4 == 4'b1100))
      c4 = ~c4;
    rdOut = ($countones(c4) == 2) ? rdMid : ($countones(c4) > 2);
    sym = {<<{c6, c4}};  // reverse so a comes first
    return sym;
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "run aborted");
  endtask

  task automatic checkSymbol(input string name, input logic [9:0] exp, input logic [9:0] got);
    if (got !== exp)
    begin
      $display("FAIL %s: expected 0x%h got 0x%h", name, exp, got);
      abortRun("symbol mismatch");
    end
  endtask

  task automatic checkWord(input string name, input elinkPkg::laneWordT exp,
                           input elinkPkg::laneWordT got);
    if (got !== exp)
    begin
      $display("FAIL %s: expected 0x%h got 0x%h", name, exp, got);
      abortRun("word mismatch");
    end
  endtask

  task automatic checkCount(input string name, input logic [15:0] exp, input logic [15:0] got);
    if (got !== exp)
    begin
      $display("FAIL %s: expected 0x%h got 0x%h", name, exp, got);
      abortRun("register value mismatch");
    end
  endtask

  // one classic cycle, entered and left 2 ns after a rising edge
  task automatic wbAccess(input logic we, input logic [3:0] adr, input logic [15:0] wdat,
                          output logic [15:0] rdat, output int waited);
    waited = 0;
    wbReq = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    do
    begin
      @(negedge getDataTrig);
      waited++;
      if (waited > ACK_LIMIT)
        abortRun($sformatf("no wishbone ack for adr %0d", adr));
    end
    while (!wbRsp.ack);
    rdat = wbRsp.dat;
    @(posedge getDataTrig);
    #DRIVE_DLY;
    wbReq = '0;
  endtask

`endif

//--- tests/elinkTxTb.sv
// e-link transmitter testbench with random words, serial capture and an 8b10b model
`timescale 1ns/1ns
module elinkTxTb;

  localparam int DRIVE_DLY       = 2;
  localparam int N_RANDOM        = 120;
  localparam int N_KWORD         = 32;
  localparam int N_BURST         = elinkPkg::QUEUE_DEPTH + 3;
  localparam int N_LEAVE         = 24;
  localparam int N_WORDS         = N_RANDOM + N_KWORD + N_BURST + N_LEAVE;
  localparam int WATCHDOG_CYCLES = N_WORDS * elinkPkg::SYM_CYCLES * 2 + 2000;
  localparam int ACK_LIMIT       = 100;

  logic                                getDataTrig;
  logic                                rstN;
  elinkPkg::wbReqT                     wbReq;
  elinkPkg::wbRspT                     wbRsp;
  logic [elinkPkg::NUM_LANES-1:0][1:0] eData;

  int                 seed = 79095;
  elinkPkg::laneWordT expQ [elinkPkg::NUM_LANES][$];  // words still due per lane
  logic               modelRd [elinkPkg::NUM_LANES];
  int                 writtenCnt [elinkPkg::NUM_LANES];
  event               symbolEnd;  // last pair of a symbol captured

  elinkClkGen u_elinkClkGen (.getDataTrig(getDataTrig), .rstN(rstN));

  elinkTxTop u_elinkTxTop (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .wbReq       (wbReq),
    .wbRsp       (wbRsp),
    .eData       (eData)
  );

  `include "elinkTxChecks.svh"

  function automatic int pendingWords();
    int n;
    n = 0;
    for (int l = 0; l < elinkPkg::NUM_LANES; l++)
      n += expQ[l].size();
    return n;
  endfunction

  // idle comma, or else the head word of the lane
  task automatic checkLaneSymbol(input int lane, input logic [9:0] got);
    logic [9:0]         idleSym;
    logic [9:0]         headSym;
    logic               rdIdle;
    logic               rdHead;
    logic               rdTry;
    logic               hit;
    elinkPkg::laneWordT found;
    idleSym = encode('{kFlag: 1'b1, data: elinkPkg::K28_5}, modelRd[lane], rdIdle);
    if (got === idleSym)
      modelRd[lane] = rdIdle;
    else if (expQ[lane].size() == 0)
      abortRun($sformatf("unexpected data symbol 0x%h on idle lane %0d", got, lane));
    else
    begin
      headSym = encode(expQ[lane][0], modelRd[lane], rdHead);
      if (got !== headSym)
      begin
        hit = 1'b0;
        found = '0;
        for (int v = 0; v < 512; v++)  // decode by search
          if (!hit && encode(elinkPkg::laneWordT'(9'(v)), modelRd[lane], rdTry) == got)
          begin
            found = elinkPkg::laneWordT'(9'(v));
            hit = 1'b1;
          end
        if (hit)
          checkWord($sformatf("eData[%0d] word", lane), expQ[lane][0], found);
        checkSymbol($sformatf("eData[%0d] symbol", lane), headSym, got);
      end
      modelRd[lane] = rdHead;
      void'(expQ[lane].pop_front());
    end
  endtask

  task automatic sendWord(input int lane, input elinkPkg::laneWordT w, output int waited);
    logic [15:0] unused;
    expQ[lane].push_back(w);
    writtenCnt[lane]++;
    wbAccess(1'b1, 4'(lane), 16'(w), unused, waited);
  endtask

  task automatic wbRead(input logic [3:0] adr, output logic [15:0] dat);
    int waited;
    wbAccess(1'b0, adr, 16'h0, dat, waited);
  endtask

  // five pairs per lane, first one the cycle after reset release
  initial
  begin : capture
    logic [9:0] sym [elinkPkg::NUM_LANES];
    wait (rstN);
    @(posedge getDataTrig);
    forever
    begin
      for (int p = 0; p < elinkPkg::SYM_CYCLES; p++)
      begin
        @(negedge getDataTrig);
        for (int l = 0; l < elinkPkg::NUM_LANES; l++)
          sym[l][2*p +: 2] = eData[l];  // earlier bit low
      end
      for (int l = 0; l < elinkPkg::NUM_LANES; l++)
        checkLaneSymbol(l, sym[l]);
      -> symbolEnd;
    end
  end

  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge getDataTrig);
    abortRun("watchdog timeout, the run did not finish in time");
  end

  initial
  begin : stimulus
    elinkPkg::laneWordT w;
    logic [15:0]        rd;
    int                 lane;
    int                 waited;
    int                 maxWait;
    wbReq = '0;
    for (int l = 0; l < elinkPkg::NUM_LANES; l++)
    begin
      modelRd[l] = 1'b0;  // RD- out of reset
      writtenCnt[l] = 0;
    end
    wait (rstN);
    @(posedge getDataTrig);
    #DRIVE_DLY;
    for (int a = 0; a < 8; a++)
    begin
      wbRead(4'(a), rd);
      checkCount($sformatf("wbRsp.dat adr %0d", a), 16'h0, rd);
    end
    repeat (10 * elinkPkg::SYM_CYCLES) @(posedge getDataTrig);  // idles only
    #DRIVE_DLY;
    for (int i = 0; i < N_RANDOM; i++)
    begin
      lane = {$random(seed)} % elinkPkg::NUM_LANES;
      w = '{kFlag: 1'b0, data: 8'($random(seed))};
      sendWord(lane, w, waited);
    end
    for (int i = 0; i < N_KWORD; i++)
    begin
      lane = {$random(seed)} % elinkPkg::NUM_LANES;
      w = '{kFlag: 1'b1, data: 8'($random(seed))};
      if (w.data[7:5] == 3'd5)
        w.data[7:5] = 3'd4;  // K28.5 looks just like an idle
      sendWord(lane, w, waited);
    end
    lane = {$random(seed)} % elinkPkg::NUM_LANES;
    maxWait = 0;
    // first burst word lands just after a symbol load, so the queue must fill
    @(symbolEnd);
    @(posedge getDataTrig);
    #DRIVE_DLY;
    for (int i = 0; i < N_BURST; i++)
    begin
      w = '{kFlag: 1'b0, data: 8'($random(seed))};
      sendWord(lane, w, waited);
      if (waited > maxWait)
        maxWait = waited;
    end
    if (maxWait <= 1)
      abortRun("burst to one lane never saw a delayed ack");
    for (int i = 0; i < N_LEAVE; i++)
    begin
      w = '{kFlag: 1'b0, data: 8'($random(seed))};
      sendWord(i % elinkPkg::NUM_LANES, w, waited);  // round robin
    end
    while (pendingWords() != 0)
      @(posedge getDataTrig);
    repeat (2) @(posedge getDataTrig);
    #DRIVE_DLY;
    for (int l = 0; l < elinkPkg::NUM_LANES; l++)
    begin
      wbRead(4'(l), rd);
      checkCount($sformatf("wbRsp.dat count lane %0d", l), 16'(writtenCnt[l]), rd);
      wbRead(4'(4 + l), rd);
      checkCount($sformatf("wbRsp.dat level lane %0d", l), 16'h0, rd);
    end
    wbRead(4'd9, rd);
    checkCount("wbRsp.dat adr 9", 16'h0, rd);  // unmapped
    $display("All tests passed!");
    $finish;
  end

endmodule
